// File: div_frac_top.f
src/div_frac_size_pkg.sv
src/div_frac_msg_pkg.sv
src/div_frac_norm.sv
src/div_frac_fifo.sv
src/div_frac_iter.sv
src/div_frac_top.sv
tb/tb_clk_gen.sv
tb/div_frac_chk.sv
tb/tb_div_frac.sv

// File: Makefile
TOP := tb_div_frac

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): div_frac_top.f src/*.sv tb/*.sv
	verilator --binary --timing --assert -j 0 -f div_frac_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --assert -f div_frac_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_div_frac.sv
// divide fraction testbench with stimulus, reference model, scoreboard and watchdog
module tb_div_frac
	import div_frac_size_pkg::*, div_frac_msg_pkg::*;
();

	localparam int DRV       = 1;		// drive delay after rising edge
	localparam int N_RAND    = 30;		// requests per random group
	localparam int N_EXACT   = 8;
	localparam int N_STALL   = 12;		// more than the pipeline holds
	localparam int STALL_CYC = 300;
	localparam int N_REQ     = 5 * N_RAND + N_EXACT + N_STALL;
	localparam int TIMEOUT   = N_REQ * (ITER_DBL + 10) + STALL_CYC + 500;
	localparam int RDY_HIGH  = 0;
	localparam int RDY_RAND  = 1;
	localparam int RDY_HOLD  = 2;

	logic		rclk;
	logic		i_rst;
	logic		i_req_valid;
	div_req_t	i_req;
	logic		o_req_ready;
	logic		o_res_valid;
	div_res_t	o_res;
	logic		i_res_ready;
	int		rdy_mode;	// result port ready pattern
	int		err_cnt;
	int		res_seen;
	logic		saw_full;	// request port stalled at least once
	div_res_t	exp_q[$];	// scoreboard
	string		name_q[$];

	tb_clk_gen u_clk (.o_clk(rclk));

	div_frac_top UUT (
		.i_rst(i_rst), .rclk(rclk),
		.i_req_valid(i_req_valid), .i_req(i_req), .o_req_ready(o_req_ready),
		.o_res_valid(o_res_valid), .o_res(o_res), .i_res_ready(i_res_ready)
	);

	bind div_frac_top div_frac_chk u_chk (
		.i_rst(i_rst), .rclk(rclk), .i_req_valid(i_req_valid), .o_req_ready(o_req_ready),
		.o_res_valid(o_res_valid), .o_res(o_res), .i_res_ready(i_res_ready)
	);

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic logic [MANT_W-1:0] ref_mant(input logic [FRAC_W-1:0] frac,
			input logic dnrm, input logic dbl, output logic [CNT_W-1:0] shl);
		logic [FRAC_W-1:0] fld;
		int top;
		fld = frac;
		top = -1;
		if (!dbl)
			fld[SNG_LSB-1:0] = '0;		// single ignores low bits
		shl = '0;
		if (!dnrm)
			return {1'b1, fld};
		for (int i = FRAC_W - 1; i >= 0; i--)
			if (fld[i] && top < 0)
				top = i;		// leading one of the field
		shl = CNT_W'(FRAC_W - top);
		return MANT_W'({1'b0, fld} << (FRAC_W - top));
	endfunction

	function automatic div_res_t model_result(input div_req_t r);
		div_res_t res;
		logic [MANT_W-1:0] m1;
		logic [MANT_W-1:0] m2;
		logic [127:0] num;
		int n;
		n = r.dblop ? ITER_DBL : ITER_SNG;
		m1 = ref_mant(r.frac_in1, r.dnrm_in1, r.dblop, res.shl_in1);
		m2 = ref_mant(r.frac_in2, r.dnrm_in2, r.dblop, res.shl_in2);
		num = 128'(m1) << (n - 1);
		res.quo    = QUO_W'(num / 128'(m2)) << (QUO_W - n);	// left aligned
		res.sticky = (num % 128'(m2)) != 0;
		res.dblop  = r.dblop;
		return res;
	endfunction

	//////////////////////////////
	// stimulus
	//////////////////////////////

	function automatic logic [FRAC_W-1:0] rand_field();
		return FRAC_W'({$urandom, $urandom});
	endfunction

	// nonzero denormal field, leading one inside the used bits
	function automatic logic [FRAC_W-1:0] rand_dnrm(input logic dbl);
		logic [FRAC_W-1:0] fld;
		int top;
		top = dbl ? int'($urandom % FRAC_W) : SNG_LSB + int'($urandom % (FRAC_W - SNG_LSB));
		fld = rand_field() & ((FRAC_W'(1) << top) - 1'b1);
		fld[top] = 1'b1;
		return fld;
	endfunction

	task automatic send_req(input string test, input div_req_t r);
		exp_q.push_back(model_result(r));
		name_q.push_back(test);
		i_req       = r;
		i_req_valid = 1'b1;
		forever begin
			@(negedge rclk);
			if (o_req_ready)
				break;		// taken at next edge
		end
		@(posedge rclk);
		#DRV;
		i_req_valid = 1'b0;
	endtask

	task automatic send_op(input string test, input logic dbl, input logic d1, input logic d2);
		div_req_t r;
		r.dblop    = dbl;
		r.dnrm_in1 = d1;
		r.dnrm_in2 = d2;
		r.frac_in1 = d1 ? rand_dnrm(dbl) : rand_field();
		r.frac_in2 = d2 ? rand_dnrm(dbl) : rand_field();
		send_req(test, r);
	endtask

	// equal operands, then a denormal dividend equal to the divisor mantissa over 2**k
	task automatic send_exact(input logic dbl, input int k);
		div_req_t r;
		logic [FRAC_W-1:0] f;
		f = rand_field() & ~((FRAC_W'(1) << (SNG_LSB + 8)) - 1'b1);	// no bits lost by >> k
		r = '{frac_in1: f, frac_in2: f, dnrm_in1: 1'b0, dnrm_in2: 1'b0, dblop: dbl};
		send_req("exact_equal", r);
		r.frac_in1 = FRAC_W'({1'b1, f} >> k);
		r.dnrm_in1 = 1'b1;
		send_req("exact_pow2", r);
	endtask

	task automatic check_val(input string test, input string field,
			input logic [63:0] exp_v, input logic [63:0] act_v);
		assert (exp_v == act_v) else begin
			$display("mismatch %s %s expected %h actual %h", test, field, exp_v, act_v);
			err_cnt++;
		end
	endtask

	always @(posedge rclk) begin
		#DRV;
		case (rdy_mode)
			RDY_RAND: i_res_ready = ($urandom % 4) != 0;
			RDY_HOLD: i_res_ready = 1'b0;
			default:  i_res_ready = 1'b1;
		endcase
	end

	//////////////////////////////
	// scoreboard
	//////////////////////////////

	// negedge sees a transfer that completes at the next rising edge
	always @(negedge rclk) begin
		div_res_t exp_res;
		string test;
		if (!i_rst && i_req_valid && !o_req_ready)
			saw_full = 1'b1;
		if (!i_rst && o_res_valid && i_res_ready) begin
			res_seen++;
			assert (exp_q.size() != 0) else begin
				$display("result arrived with no request outstanding");
				err_cnt++;
			end
			if (exp_q.size() != 0) begin
				exp_res = exp_q.pop_front();
				test    = name_q.pop_front();
				check_val(test, "quo", 64'(exp_res.quo), 64'(o_res.quo));
				check_val(test, "sticky", 64'(exp_res.sticky), 64'(o_res.sticky));
				check_val(test, "shl_in1", 64'(exp_res.shl_in1), 64'(o_res.shl_in1));
				check_val(test, "shl_in2", 64'(exp_res.shl_in2), 64'(o_res.shl_in2));
				check_val(test, "dblop", 64'(exp_res.dblop), 64'(o_res.dblop));
			end
		end
	end

	initial begin
		repeat (TIMEOUT) @(posedge rclk);
		$display("watchdog expired after %0d cycles, %0d results never arrived",
			TIMEOUT, exp_q.size());
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(5235));
		i_rst       = 1'b1;
		i_req_valid = 1'b0;
		i_req       = '0;
		i_res_ready = 1'b1;
		rdy_mode    = RDY_HIGH;
		err_cnt     = 0;
		res_seen    = 0;
		saw_full    = 1'b0;
		repeat (16) @(posedge rclk);
		#DRV;
		i_rst = 1'b0;
		repeat (N_RAND) send_op("dbl_normal", 1'b1, 1'b0, 1'b0);
		repeat (N_RAND) send_op("sng_normal", 1'b0, 1'b0, 1'b0);
		for (int i = 0; i < N_RAND; i++)
			send_op("denormal", 1'($urandom), i[0], ~i[0] | 1'($urandom));
		for (int i = 0; i < N_EXACT / 2; i++)
			send_exact(i[0], 1 + int'($urandom % 8));
		rdy_mode = RDY_HOLD;		// long stall, fills back to the request port
		fork
			repeat (N_STALL) send_op("stall", 1'($urandom), 1'($urandom), 1'($urandom));
			begin
				repeat (STALL_CYC) @(posedge rclk);
				rdy_mode = RDY_RAND;
			end
		join
		repeat (N_RAND) send_op("rand_ready", 1'($urandom), 1'($urandom), 1'($urandom));
		rdy_mode = RDY_HIGH;
		repeat (N_RAND) send_op("back_to_back", 1'($urandom), 1'($urandom), 1'($urandom));
		while (exp_q.size() != 0)
			@(posedge rclk);
		repeat (4) @(posedge rclk);
		assert (saw_full) else begin
			$display("request port never stalled under result back-pressure");
			err_cnt++;
		end
		assert (res_seen == N_REQ) else begin
			$display("result count differs from request count");
			err_cnt++;
		end
		$display("results %0d of %0d, scoreboard errors %0d, assertion failures %0d",
			res_seen, N_REQ, err_cnt, UUT.u_chk.fail_cnt);
		if (err_cnt == 0 && UUT.u_chk.fail_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: tb/div_frac_chk.sv
// concurrent handshake, reset, quotient and ordering checks for the divide fraction top
module div_frac_chk
	import div_frac_size_pkg::*, div_frac_msg_pkg::*;
(
	input logic		i_rst,
	input logic		rclk,
	input logic		i_req_valid,
	input logic		o_req_ready,
	input logic		o_res_valid,
	input div_res_t		o_res,
	input logic		i_res_ready
);

	int unsigned	req_cnt;	// accepted requests
	int unsigned	res_cnt;	// delivered results
	int		fail_cnt = 0;	// failed assertions so far

	always_ff @(posedge rclk) begin
		if (i_rst) begin
			req_cnt <= 0;
			res_cnt <= 0;
		end else begin
			if (i_req_valid && o_req_ready)
				req_cnt <= req_cnt + 1;
			if (o_res_valid && i_res_ready)
				res_cnt <= res_cnt + 1;
		end
	end

	//////////////////////////////
	// result port
	//////////////////////////////

	a_res_hold: assert property (@(posedge rclk) disable iff (i_rst)
		o_res_valid && !i_res_ready |=> o_res_valid && $stable(o_res))
	else begin
		$error("result withdrawn or changed while stalled");
		fail_cnt++;
	end

	a_rst_idle: assert property (@(posedge rclk) i_rst |=> !o_res_valid)
	else begin
		$error("result valid in the cycle after reset");
		fail_cnt++;
	end

	// normalized operands keep the ratio in (0.5, 2)
	a_quo_top: assert property (@(posedge rclk) disable iff (i_rst)
		o_res_valid |-> o_res.quo[QUO_W-1 -: 2] != 2'b00)
	else begin
		$error("quotient has both top bits clear");
		fail_cnt++;
	end

	a_order: assert property (@(posedge rclk) disable iff (i_rst)
		o_res_valid && i_res_ready |-> req_cnt > res_cnt)
	else begin
		$error("result delivered without an outstanding request");
		fail_cnt++;
	end

endmodule

// File: tb/tb_clk_gen.sv
// free running testbench clock source
module tb_clk_gen (
	output logic	o_clk
);

	localparam int HALF = 4;	// period 8

	initial o_clk = 1'b0;

	always #HALF o_clk = ~o_clk;

endmodule

// File: src/div_frac_top.sv
// divide fraction subsystem top with normalizer, request buffer, divider and result buffer
module div_frac_top
	import div_frac_size_pkg::*, div_frac_msg_pkg::*;
(
	input  logic		i_rst,
	input  logic		rclk,
	input  logic		i_req_valid,
	input  div_req_t	i_req,
	output logic		o_req_ready,
	output logic		o_res_valid,
	output div_res_t	o_res,
	input  logic		i_res_ready
);

	logic		norm_valid;	// normalizer to request buffer
	logic		norm_ready;
	div_norm_t	norm;
	logic		buf_valid;	// request buffer to divider
	logic		buf_ready;
	div_norm_t	buf_norm;
	logic		res_valid;	// divider to result buffer
	logic		res_ready;
	div_res_t	res;

	div_frac_norm u_norm (
		.i_rst(i_rst), .rclk(rclk),
		.i_req_valid(i_req_valid), .i_req(i_req), .o_req_ready(o_req_ready),
		.o_norm_valid(norm_valid), .o_norm(norm), .i_norm_ready(norm_ready)
	);

	div_frac_fifo #(.T(div_norm_t), .DEPTH(BUF_DEPTH)) u_req_buf (
		.i_rst(i_rst), .rclk(rclk),
		.i_valid(norm_valid), .i_data(norm), .o_ready(norm_ready),
		.o_valid(buf_valid), .o_data(buf_norm), .i_ready(buf_ready)
	);

	div_frac_iter u_iter (
		.i_rst(i_rst), .rclk(rclk),
		.i_norm_valid(buf_valid), .i_norm(buf_norm), .o_norm_ready(buf_ready),
		.o_res_valid(res_valid), .o_res(res), .i_res_ready(res_ready)
	);

	div_frac_fifo #(.T(div_res_t), .DEPTH(BUF_DEPTH)) u_res_buf (
		.i_rst(i_rst), .rclk(rclk),
		.i_valid(res_valid), .i_data(res), .o_ready(res_ready),
		.o_valid(o_res_valid), .o_data(o_res), .i_ready(i_res_ready)
	);

endmodule

// File: src/div_frac_iter.sv
// restoring divide engine, one quotient bit per cycle, with sticky and shift passthrough
module div_frac_iter
	import div_frac_size_pkg::*, div_frac_msg_pkg::*;
(
	input  logic		i_rst,
	input  logic		rclk,
	input  logic		i_norm_valid,
	input  div_norm_t	i_norm,
	output logic		o_norm_ready,
	output logic		o_res_valid,
	output div_res_t	o_res,
	input  logic		i_res_ready
);

	typedef enum logic [1:0] {
		S_IDLE,		// waiting for operands
		S_RUN,		// one quotient bit per cycle
		S_PRES,		// align and register result
		S_OUT		// result offered downstream
	} state_t;

	state_t			state;
	logic [ITER_W-1:0]	iter_cnt;	// iterations left
	div_norm_t		op;		// held operands and shifts
	logic [REM_W-1:0]	rem;		// partial remainder
	logic [QUO_W-1:0]	quo;		// right filled quotient
	logic [REM_W-1:0]	rem_sub;
	logic			q_bit;
	logic [QUO_W-1:0]	quo_algn;

	//////////////////////////////
	// compare and subtract
	//////////////////////////////

	assign q_bit    = (rem >= {1'b0, op.mant_in2});	// remainder not smaller
	assign rem_sub  = rem - {1'b0, op.mant_in2};
	assign quo_algn = op.dblop ? quo : quo << SNG_ALIGN;

	assign o_norm_ready = (state == S_IDLE);	// busy until result taken
	assign o_res_valid  = (state == S_OUT);

	//////////////////////////////
	// control FSM
	//////////////////////////////

	always_ff @(posedge rclk) begin
		if (i_rst) begin
			state    <= S_IDLE;
			iter_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_norm_valid) begin
						state    <= S_RUN;
						iter_cnt <= i_norm.dblop ? ITER_W'(ITER_DBL)
									 : ITER_W'(ITER_SNG);
					end
				end
				S_RUN: begin
					iter_cnt <= iter_cnt - 1'b1;
					if (iter_cnt == ITER_W'(1))
						state <= S_PRES;	// last bit this edge
				end
				S_PRES: begin
					state <= S_OUT;
				end
				S_OUT: begin
					if (i_res_ready)
						state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// datapath registers
	//////////////////////////////

	always_ff @(posedge rclk) begin
		case (state)
			S_IDLE: begin
				if (i_norm_valid) begin
					op  <= i_norm;
					rem <= {1'b0, i_norm.mant_in1};	// dividend
					quo <= '0;
				end
			end
			S_RUN: begin
				quo <= {quo[QUO_W-2:0], q_bit};
				rem <= (q_bit ? rem_sub : rem) << 1;	// restore or keep, then double
			end
			S_PRES: begin
				o_res.quo     <= quo_algn;
				o_res.sticky  <= |rem;		// inexact
				o_res.shl_in1 <= op.shl_in1;
				o_res.shl_in2 <= op.shl_in2;
				o_res.dblop   <= op.dblop;
			end
			default: begin
				o_res <= o_res;			// hold while offered
			end
		endcase
	end

endmodule

// File: src/div_frac_fifo.sv
// valid/ready circular buffer FIFO with a type parameter for its payload
module div_frac_fifo #(
	parameter type	T     = logic,
	parameter int	DEPTH = 2
) (
	input  logic	i_rst,
	input  logic	rclk,
	input  logic	i_valid,
	input  T	i_data,
	output logic	o_ready,
	output logic	o_valid,
	output T	o_data,
	input  logic	i_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int OCC_W = $clog2(DEPTH + 1);

	// wrap at DEPTH, any depth allowed
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	T			mem [DEPTH];	// entry storage
	logic [PTR_W-1:0]	wr_ptr;
	logic [PTR_W-1:0]	rd_ptr;
	logic [OCC_W-1:0]	occ;		// entries held
	logic			full;
	logic			push;
	logic			pop;

	assign full    = (occ == OCC_W'(DEPTH));
	assign o_ready = ~full | i_ready;	// full but draining still accepts
	assign o_valid = (occ != '0);
	assign o_data  = mem[rd_ptr];
	assign push    = i_valid & o_ready;
	assign pop     = o_valid & i_ready;

	always_ff @(posedge rclk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push && !pop)
				occ <= occ + 1'b1;
			else if (pop && !push)
				occ <= occ - 1'b1;
		end
	end

	always_ff @(posedge rclk) begin
		if (push)
			mem[wr_ptr] <= i_data;	// visible next cycle
	end

endmodule

// File: src/div_frac_norm.sv
// two stage operand normalizer with hidden bit restore, leading zero count and left shift
module div_frac_norm
	import div_frac_size_pkg::*, div_frac_msg_pkg::*;
(
	input  logic		i_rst,
	input  logic		rclk,
	input  logic		i_req_valid,
	input  div_req_t	i_req,
	output logic		o_req_ready,
	output logic		o_norm_valid,
	output div_norm_t	o_norm,
	input  logic		i_norm_ready
);

	// builds the pre-shift mantissa from a field
	function automatic logic [MANT_W-1:0] form_mant(
		input logic [FRAC_W-1:0]	frac,
		input logic			dnrm,
		input logic			dblop
	);
		logic [FRAC_W-1:0] fld;		// field as the precision sees it
		fld = dblop ? frac : {frac[FRAC_W-1:SNG_LSB], {SNG_LSB{1'b0}}};
		return {~dnrm, fld};		// denormal keeps hidden bit clear
	endfunction

	// leading zero count, highest set bit wins
	function automatic logic [CNT_W-1:0] lead0(input logic [MANT_W-1:0] m);
		logic [CNT_W-1:0] cnt;
		cnt = '0;
		for (int i = 0; i < MANT_W; i++) begin
			if (m[i])
				cnt = CNT_W'(MANT_W - 1 - i);
		end
		return cnt;
	endfunction

	logic			s1_valid;	// stage one full
	logic			s2_valid;	// stage two full
	logic			s1_take;	// request accepted
	logic			s2_take;	// stage two can load
	logic [MANT_W-1:0]	mant1_in;
	logic [MANT_W-1:0]	mant2_in;
	logic [MANT_W-1:0]	s1_mant1;	// pre-shift dividend
	logic [MANT_W-1:0]	s1_mant2;	// pre-shift divisor
	logic [CNT_W-1:0]	s1_lz1;
	logic [CNT_W-1:0]	s1_lz2;
	logic			s1_dblop;

	assign mant1_in = form_mant(i_req.frac_in1, i_req.dnrm_in1, i_req.dblop);
	assign mant2_in = form_mant(i_req.frac_in2, i_req.dnrm_in2, i_req.dblop);

	//////////////////////////////
	// pipeline handshake
	//////////////////////////////

	assign s2_take      = ~s2_valid | i_norm_ready;	// empty or draining
	assign o_req_ready  = ~s1_valid | s2_take;
	assign s1_take      = i_req_valid & o_req_ready;
	assign o_norm_valid = s2_valid;

	always_ff @(posedge rclk) begin
		if (i_rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (o_req_ready)
				s1_valid <= i_req_valid;	// load or bubble
			if (s2_take)
				s2_valid <= s1_valid;
		end
	end

	//////////////////////////////
	// stage payloads
	//////////////////////////////

	always_ff @(posedge rclk) begin
		if (s1_take) begin
			s1_mant1 <= mant1_in;
			s1_mant2 <= mant2_in;
			s1_lz1   <= lead0(mant1_in);	// zero for normals
			s1_lz2   <= lead0(mant2_in);
			s1_dblop <= i_req.dblop;
		end
		if (s1_valid && s2_take) begin
			o_norm.mant_in1 <= s1_mant1 << s1_lz1;	// top bit now set
			o_norm.mant_in2 <= s1_mant2 << s1_lz2;
			o_norm.shl_in1  <= s1_lz1;
			o_norm.shl_in2  <= s1_lz2;
			o_norm.dblop    <= s1_dblop;
		end
	end

endmodule

// File: src/div_frac_msg_pkg.sv
// request, normalized operand and result message structs of the divide fraction datapath
package div_frac_msg_pkg;
	import div_frac_size_pkg::*;

	//////////////////////////////
	// operand request
	//////////////////////////////

	typedef struct packed {
		logic [FRAC_W-1:0]	frac_in1;	// dividend fraction field
		logic [FRAC_W-1:0]	frac_in2;	// divisor fraction field
		logic			dnrm_in1;	// dividend is denormal
		logic			dnrm_in2;	// divisor is denormal
		logic			dblop;		// 1 double, 0 single
	} div_req_t;

	//////////////////////////////
	// normalized operands
	//////////////////////////////

	typedef struct packed {
		logic [MANT_W-1:0]	mant_in1;	// top bit always set
		logic [MANT_W-1:0]	mant_in2;
		logic [CNT_W-1:0]	shl_in1;	// left shift applied to in1
		logic [CNT_W-1:0]	shl_in2;	// left shift applied to in2
		logic			dblop;
	} div_norm_t;

	//////////////////////////////
	// divide result
	//////////////////////////////

	typedef struct packed {
		logic [QUO_W-1:0]	quo;		// left aligned quotient
		logic			sticky;		// nonzero final remainder
		logic [CNT_W-1:0]	shl_in1;	// passed through for exponent fixup
		logic [CNT_W-1:0]	shl_in2;
		logic			dblop;
	} div_res_t;

endpackage

// File: src/div_frac_size_pkg.sv
// width and iteration count constants for the divide fraction datapath
package div_frac_size_pkg;

	//////////////////////////////
	// field and register widths
	//////////////////////////////

	localparam int FRAC_W  = 52;		// operand fraction field
	localparam int MANT_W  = 53;		// mantissa incl hidden bit
	localparam int REM_W   = MANT_W + 1;	// partial remainder, one guard bit
	localparam int QUO_W   = 55;		// quotient register
	localparam int CNT_W   = 6;		// normalize shift count
	localparam int SNG_LSB = 29;		// lowest field bit used by single

	//////////////////////////////
	// iteration control
	//////////////////////////////

	localparam int ITER_DBL  = 55;			// quotient bits, double
	localparam int ITER_SNG  = 26;			// quotient bits, single
	localparam int ITER_W    = 6;			// iteration counter width
	localparam int SNG_ALIGN = QUO_W - ITER_SNG;	// left align of single quotient

	// decoupling buffers
	localparam int BUF_DEPTH = 2;		// entries per buffer

endpackage
